// ==== Makefile ====
# Verilator build and run for the chess display

VERILATOR ?= verilator
TOP       ?= tb_chess_display
RTL_TOP   ?= chess_display
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run passed" || { echo "run failed"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/board_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_store (
    input  logic                   clock,
    input  logic                   rst_n,
    input  chess_pkg::move_t       move,
    input  chess_pkg::square_idx_t rd_square,
    output chess_pkg::square_t     rd_data
);

    localparam chess_pkg::square_t empty_sq = '{side: chess_pkg::WHITE,
                                                kind: chess_pkg::EMPTY};

    chess_pkg::square_t board [64];

    // back rank from file 0 to file 7
    function automatic chess_pkg::piece_kind_e back_rank(input logic [2:0] file);
        chess_pkg::piece_kind_e kind;
        case (file)
            3'd0, 3'd7: kind = chess_pkg::ROOK;
            3'd1, 3'd6: kind = chess_pkg::KNIGHT;
            3'd2, 3'd5: kind = chess_pkg::BISHOP;
            3'd3:       kind = chess_pkg::KING;
            default:    kind = chess_pkg::QUEEN;
        endcase
        return kind;
    endfunction

    // black at the top, white at the bottom
    function automatic chess_pkg::square_t opening(input chess_pkg::square_idx_t idx);
        chess_pkg::square_t sq;
        sq = empty_sq;
        case (idx[5:3])
            3'd0: sq = '{side: chess_pkg::BLACK, kind: back_rank(idx[2:0])};
            3'd1: sq = '{side: chess_pkg::BLACK, kind: chess_pkg::PAWN};
            3'd6: sq = '{side: chess_pkg::WHITE, kind: chess_pkg::PAWN};
            3'd7: sq = '{side: chess_pkg::WHITE, kind: back_rank(idx[2:0])};
            default: sq = empty_sq;
        endcase
        return sq;
    endfunction

    ////////////////////
    // board registers
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 64; i++)
                board[i] <= opening(chess_pkg::square_idx_t'(i));
        end
        else if (move.valid)
        begin
            // source cleared last, so a move onto itself empties the square
            board[move.to_sq]   <= board[move.from_sq];
            board[move.from_sq] <= empty_sq;
        end
    end

    // read is combinational, new contents visible after the write edge
    assign rd_data = board[rd_square];

endmodule

`default_nettype wire

// ==== src/chess_defs.svh ====
`ifndef CHESS_DEFS_SVH
`define CHESS_DEFS_SVH

////////////////////
// display geometry
////////////////////

// panel size in pixels, index runs row by row
`define SCREEN_W 96
`define SCREEN_H 64

////////////////////
// board placement
////////////////////

// first column of file 0, board spans 8 squares to column 79
`define BOARD_X0 16
`define SQ_SIZE  8

////////////////////
// rgb565 colours
////////////////////

// pieces, pink for white side
`define COL_WHITE_PIECE   16'hDBB1
`define COL_BLACK_PIECE   16'h0000

// squares, brown for the dark ones
`define COL_WHITE_SQ      16'hFFFF
`define COL_BLACK_SQ      16'h9262

`define COL_BORDER        16'h0000

// mouse cross, light blue arms with black corners
`define COL_CURSOR_ARM    16'h7EF7
`define COL_CURSOR_CORNER 16'h0000

`endif

// ==== src/chess_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module chess_display (
    input  logic                    clock,
    input  logic                    rst_n,
    input  display_pkg::pix_idx_t   pix_index,
    input  logic                    player,
    input  display_pkg::cursor_t    cursor,
    input  chess_pkg::move_t        move,
    output display_pkg::rgb565_t    oled_data,
    output display_pkg::selection_t selection
);

    chess_pkg::square_idx_t rd_square;
    chess_pkg::square_t     rd_data;
    chess_pkg::piece_kind_e glyph_kind;
    logic [2:0]             glyph_row;
    logic [7:0]             row_bits;

    ////////////////////
    // pixel path
    ////////////////////

    pixel_shader u_pixel_shader (
        .clock      (clock),
        .rst_n      (rst_n),
        .pix_index  (pix_index),
        .player     (player),
        .cursor     (cursor),
        .rd_square  (rd_square),
        .rd_data    (rd_data),
        .glyph_kind (glyph_kind),
        .glyph_row  (glyph_row),
        .row_bits   (row_bits),
        .oled_data  (oled_data)
    );

    // board contents, read by stage 2 of the shader
    board_store u_board_store (
        .clock     (clock),
        .rst_n     (rst_n),
        .move      (move),
        .rd_square (rd_square),
        .rd_data   (rd_data)
    );

    glyph_rom u_glyph_rom (
        .kind     (glyph_kind),
        .row      (glyph_row),
        .row_bits (row_bits)
    );

    ////////////////////
    // mouse selection
    ////////////////////

    square_picker u_square_picker (
        .clock     (clock),
        .rst_n     (rst_n),
        .cursor    (cursor),
        .player    (player),
        .selection (selection)
    );

endmodule

`default_nettype wire

// ==== src/chess_pkg.sv ====
`default_nettype none

package chess_pkg;

    // piece codes as held in the board registers
    typedef enum logic [2:0] {
        EMPTY  = 3'd0,
        PAWN   = 3'd1,
        BISHOP = 3'd2,
        KNIGHT = 3'd3,
        ROOK   = 3'd4,
        QUEEN  = 3'd5,
        KING   = 3'd6
    } piece_kind_e;

    typedef enum logic {
        WHITE = 1'b0,
        BLACK = 1'b1
    } side_e;

    // one board square, side in the top bit
    typedef struct packed {
        side_e       side;
        piece_kind_e kind;
    } square_t;

    // rank * 8 + file, rank 0 is the top row in the normal view
    typedef logic [5:0] square_idx_t;

    // valid is a single-cycle strobe
    typedef struct packed {
        logic        valid;
        square_idx_t from_sq;
        square_idx_t to_sq;
    } move_t;

endpackage

`default_nettype wire

// ==== src/display_pkg.sv ====
`default_nettype none

package display_pkg;

    // row * 96 + column
    typedef logic [12:0] pix_idx_t;

    // one pixel column or row, wide enough for off-screen parking
    typedef logic [6:0] coord_t;

    typedef logic [15:0] rgb565_t;

    // mouse state, all levels
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   left;
    } cursor_t;

    // square picked by the last left click on the board
    typedef struct packed {
        logic                   valid;
        chess_pkg::square_idx_t square;
    } selection_t;

endpackage

`default_nettype wire

// ==== src/glyph_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module glyph_rom (
    input  chess_pkg::piece_kind_e kind,
    input  logic [2:0]             row,
    output logic [7:0]             row_bits
);

    // row 0 in the top byte, bit 7 of each row is column 0
    logic [63:0] glyph;

    always_comb
    begin
        case (kind)
            chess_pkg::PAWN:
                glyph = {8'b0000_0000, 8'b0001_1000, 8'b0011_1100, 8'b0011_1100,
                         8'b0001_1000, 8'b0001_1000, 8'b0001_1000, 8'b0111_1110};
            chess_pkg::BISHOP:
                glyph = {8'b0000_0000, 8'b0001_1000, 8'b0011_1100, 8'b0111_1010,
                         8'b0111_0110, 8'b0111_1110, 8'b0011_1100, 8'b0111_1110};
            // row 2 read as columns 2 to 5
            chess_pkg::KNIGHT:
                glyph = {8'b0000_0000, 8'b0001_0000, 8'b0011_1100, 8'b0101_1110,
                         8'b0111_1110, 8'b0100_1110, 8'b0001_1100, 8'b0111_1110};
            chess_pkg::ROOK:
                glyph = {8'b0000_0000, 8'b0101_1010, 8'b0111_1110, 8'b0111_1110,
                         8'b0001_1000, 8'b0001_1000, 8'b0011_1100, 8'b0111_1110};
            // crown starts one row lower, row 1 stays empty
            chess_pkg::QUEEN:
                glyph = {8'b0000_0000, 8'b0000_0000, 8'b0111_1110, 8'b0101_1010,
                         8'b0101_1010, 8'b0011_1100, 8'b0000_0000, 8'b0111_1110};
            chess_pkg::KING:
                glyph = {8'b0000_0000, 8'b0101_1010, 8'b0000_0000, 8'b0101_1010,
                         8'b0101_1010, 8'b0111_1110, 8'b0011_1100, 8'b0111_1110};
            default:
                glyph = '0;
        endcase
    end

    // byte offset counts down from the top row
    assign row_bits = glyph[{~row, 3'b000} +: 8];

endmodule

`default_nettype wire

// ==== src/pixel_shader.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "chess_defs.svh"

module pixel_shader (
    input  logic                   clock,
    input  logic                   rst_n,
    input  display_pkg::pix_idx_t  pix_index,
    input  logic                   player,
    input  display_pkg::cursor_t   cursor,
    output chess_pkg::square_idx_t rd_square,
    input  chess_pkg::square_t     rd_data,
    output chess_pkg::piece_kind_e glyph_kind,
    output logic [2:0]             glyph_row,
    input  logic [7:0]             row_bits,
    output display_pkg::rgb565_t   oled_data
);

    localparam display_pkg::coord_t board_x_lo = display_pkg::coord_t'(`BOARD_X0);
    localparam display_pkg::coord_t board_x_hi =
        display_pkg::coord_t'(`BOARD_X0 + 8 * `SQ_SIZE - 1);
    localparam display_pkg::pix_idx_t screen_w = display_pkg::pix_idx_t'(`SCREEN_W);

    typedef struct packed {
        display_pkg::coord_t    x;
        display_pkg::coord_t    y;
        logic [2:0]             col;
        logic                   parity;
        logic                   border;
        chess_pkg::square_idx_t square;
    } stage1_t;

    ////////////////////
    // stage 1
    ////////////////////

    display_pkg::coord_t    x;
    display_pkg::coord_t    y;
    display_pkg::coord_t    bx;
    chess_pkg::square_idx_t view_sq;
    stage1_t                s1;

    assign x  = display_pkg::coord_t'(pix_index % screen_w);
    assign y  = display_pkg::coord_t'(pix_index / screen_w);
    assign bx = x - board_x_lo;

    // normal-view square, rank from y and file from board column
    assign view_sq = {y[5:3], bx[5:3]};

    always_ff @(posedge clock)
    begin
        s1.x      <= x;
        s1.y      <= y;
        s1.col    <= bx[2:0];
        s1.parity <= bx[3] ^ y[3];
        s1.border <= (x < board_x_lo) || (x > board_x_hi);
        s1.square <= player ? 6'd63 - view_sq : view_sq;
    end

    ////////////////////
    // stage 2
    ////////////////////

    logic [7:0] px;
    logic [7:0] py;
    logic [7:0] cx;
    logic [7:0] cy;
    logic       x_on, x_left, x_right;
    logic       y_on, y_up, y_down;
    logic       arm;
    logic       corner;
    logic       piece_hit;

    assign rd_square  = s1.square;
    assign glyph_kind = rd_data.kind;
    assign glyph_row  = s1.y[2:0];
    assign piece_hit  = row_bits[~s1.col];

    // one extra bit so a cursor near the edge never wraps
    assign px = {1'b0, s1.x};
    assign py = {1'b0, s1.y};
    assign cx = {1'b0, cursor.x};
    assign cy = {1'b0, cursor.y};

    assign x_on    = px == cx;
    assign x_left  = px + 8'd1 == cx;
    assign x_right = px == cx + 8'd1;
    assign y_on    = py == cy;
    assign y_up    = py + 8'd1 == cy;
    assign y_down  = py == cy + 8'd1;

    assign arm    = (x_on && (y_on || y_up || y_down)) || (y_on && (x_left || x_right));
    assign corner = (x_left || x_right) && (y_up || y_down);

    // cursor over border over piece over square
    always_ff @(posedge clock)
    begin
        if (!rst_n)
            oled_data <= '0;
        else if (arm)
            oled_data <= `COL_CURSOR_ARM;
        else if (corner)
            oled_data <= `COL_CURSOR_CORNER;
        else if (s1.border)
            oled_data <= `COL_BORDER;
        else if (piece_hit)
            oled_data <= (rd_data.side == chess_pkg::WHITE) ? `COL_WHITE_PIECE
                                                            : `COL_BLACK_PIECE;
        else
            oled_data <= s1.parity ? `COL_BLACK_SQ : `COL_WHITE_SQ;
    end

endmodule

`default_nettype wire

// ==== src/square_picker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "chess_defs.svh"

module square_picker (
    input  logic                    clock,
    input  logic                    rst_n,
    input  display_pkg::cursor_t    cursor,
    input  logic                    player,
    output display_pkg::selection_t selection
);

    localparam display_pkg::coord_t board_x_lo = display_pkg::coord_t'(`BOARD_X0);
    localparam display_pkg::coord_t board_x_hi =
        display_pkg::coord_t'(`BOARD_X0 + 8 * `SQ_SIZE - 1);
    localparam display_pkg::coord_t board_y_end = display_pkg::coord_t'(`SCREEN_H);

    display_pkg::coord_t    bx;
    chess_pkg::square_idx_t view_sq;
    logic                   on_board;

    assign bx = cursor.x - board_x_lo;

    // same mapping as the pixel path
    assign view_sq = {cursor.y[5:3], bx[5:3]};

    assign on_board = (cursor.x >= board_x_lo) && (cursor.x <= board_x_hi)
                   && (cursor.y < board_y_end);

    ////////////////////
    // click capture
    ////////////////////

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            selection <= '0;
        end
        else if (cursor.left)
        begin
            if (on_board)
            begin
                selection.valid  <= 1'b1;
                selection.square <= player ? 6'd63 - view_sq : view_sq;
            end
            else
            begin
                // click beside the board drops the selection
                selection.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_chess_display.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "chess_defs.svh"

module tb_chess_display;

    localparam int clk_period  = 8;
    localparam int num_moves   = 8;
    localparam int num_cursors = 16;
    localparam int num_clicks  = 24;

    // cycles for reset sweeps, two full boards, moves, cursor and clicks
    localparam int run_cycles = 4 + 2048 + 512 + 2 * 4096 + num_moves * 140
                              + num_cursors * 14 + 2 * num_clicks * 2;

    localparam display_pkg::cursor_t park = '{x: 7'd127, y: 7'd127, left: 1'b0};

    logic                    clock;
    logic                    rst_n;
    logic                    player;
    display_pkg::pix_idx_t   pix_index;
    display_pkg::cursor_t    cursor;
    chess_pkg::move_t        move;
    display_pkg::rgb565_t    oled_data;
    display_pkg::selection_t selection;

    // board mirror that follows every move driven into the DUT
    chess_pkg::square_t model [64];

    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int test_start   = 0;

    chess_display u_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .pix_index (pix_index),
        .player    (player),
        .cursor    (cursor),
        .move      (move),
        .oled_data (oled_data),
        .selection (selection)
    );

    initial
    begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    initial
    begin
        #(longint'(run_cycles + 500) * clk_period);
        $display("watchdog expired after %0d cycles", run_cycles + 500);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // helpers
    ////////////////////

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    function automatic chess_pkg::square_t opening_square(input int idx);
        chess_pkg::piece_kind_e back [8] = '{chess_pkg::ROOK, chess_pkg::KNIGHT,
            chess_pkg::BISHOP, chess_pkg::KING, chess_pkg::QUEEN, chess_pkg::BISHOP,
            chess_pkg::KNIGHT, chess_pkg::ROOK};
        chess_pkg::square_t sq;
        sq.side = (idx < 32) ? chess_pkg::BLACK : chess_pkg::WHITE;
        case (idx / 8)
            0, 7:    sq.kind = back[idx % 8];
            1, 6:    sq.kind = chess_pkg::PAWN;
            default: sq = '0;
        endcase
        return sq;
    endfunction

    // returns 0 where the glyph bit under the pixel is not fixed
    function automatic bit expected_colour(input int x, input int y,
                                           output logic [15:0] col);
        int dx;
        int dy;
        int file;
        int rank;
        chess_pkg::square_t s;
        logic [15:0] sq_col;
        bit known;
        known = 1'b1;
        col = '0;
        dx = x - int'(cursor.x);
        dy = y - int'(cursor.y);
        if ((dx == 0 && dy >= -1 && dy <= 1) || (dy == 0 && (dx == 1 || dx == -1)))
            col = `COL_CURSOR_ARM;
        else if ((dx == 1 || dx == -1) && (dy == 1 || dy == -1))
            col = `COL_CURSOR_CORNER;
        else if (x < `BOARD_X0 || x > `BOARD_X0 + 8 * `SQ_SIZE - 1)
            col = `COL_BORDER;
        else
        begin
            file = (x - `BOARD_X0) / `SQ_SIZE;
            rank = y / `SQ_SIZE;
            s = model[player ? 63 - (rank * 8 + file) : rank * 8 + file];
            sq_col = ((rank + file) % 2 == 0) ? `COL_WHITE_SQ : `COL_BLACK_SQ;
            if (s.kind == chess_pkg::EMPTY || y % 8 == 0 || (x - `BOARD_X0) % 8 == 0
                || (x - `BOARD_X0) % 8 == 7)
                col = sq_col;
            else if (s.kind == chess_pkg::QUEEN && y % 8 == 1)
                col = sq_col;
            else if (y % 8 == 7)
                col = (s.side == chess_pkg::WHITE) ? `COL_WHITE_PIECE : `COL_BLACK_PIECE;
            else
                known = 1'b0;
        end
        return known;
    endfunction

    task automatic check_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            $display("Mismatch %s: got %h expected %h", what, got, exp);
            errors++;
        end
    endtask

    // back-to-back sweep with each result compared two edges after its index
    task automatic run_pixels(input int x0, input int x1, input int y0, input int y1);
        logic [15:0] exp_q [$];
        bit          known_q [$];
        int          loc_q [$];
        logic [15:0] col;
        bit          known;
        int          loc;
        int          w;
        int          total;
        w = x1 - x0 + 1;
        total = w * (y1 - y0 + 1);
        for (int i = 0; i < total + 2; i++)
        begin
            step();
            if (i >= 2)
            begin
                loc = loc_q.pop_front();
                known = known_q.pop_front();
                col = exp_q.pop_front();
                checks++;
                assert (!known || oled_data === col)
                else
                begin
                    $display("Mismatch oled_data at x=%0d y=%0d: got %h expected %h",
                             loc % 256, loc / 256, oled_data, col);
                    errors++;
                end
            end
            if (i < total)
            begin
                loc = (y0 + i / w) * 256 + x0 + i % w;
                pix_index = display_pkg::pix_idx_t'((loc / 256) * `SCREEN_W + loc % 256);
                known = expected_colour(loc % 256, loc / 256, col);
                loc_q.push_back(loc);
                known_q.push_back(known);
                exp_q.push_back(col);
            end
        end
    endtask

    task automatic run_square(input int sq);
        run_pixels(`BOARD_X0 + (sq % 8) * 8, `BOARD_X0 + (sq % 8) * 8 + 7,
                   (sq / 8) * 8, (sq / 8) * 8 + 7);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start)
            $display("test %s passed", name);
        else
        begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic reset_state();
        check_value("oled_data", oled_data, 16'h0000);
        check_value("selection.valid", {15'b0, selection.valid}, 16'h0000);
        run_pixels(0, 15, 0, 63);
        run_pixels(80, 95, 0, 63);
        for (int r = 0; r < 8; r++)
            run_pixels(16, 79, r * 8, r * 8);
        end_test("reset");
    endtask

    task automatic board_view(input logic view, input string name);
        player = view;
        run_pixels(16, 79, 0, 63);
        player = 1'b0;
        end_test(name);
    endtask

    task automatic random_moves();
        int from_sq;
        int to_sq;
        repeat (num_moves)
        begin
            do from_sq = $urandom_range(63, 0); while (model[from_sq].kind == chess_pkg::EMPTY);
            do to_sq = $urandom_range(63, 0); while (model[to_sq].kind != chess_pkg::EMPTY);
            move.valid = 1'b1;
            move.from_sq = chess_pkg::square_idx_t'(from_sq);
            move.to_sq = chess_pkg::square_idx_t'(to_sq);
            step();
            move.valid = 1'b0;
            model[to_sq] = model[from_sq];
            model[from_sq] = '0;
            run_square(to_sq);
            run_square(from_sq);
        end
        end_test("moves");
    endtask

    task automatic cursor_overlay();
        int cx;
        int cy;
        repeat (num_cursors)
        begin
            cx = $urandom_range(78, 17);
            cy = $urandom_range(62, 1);
            cursor = '{x: display_pkg::coord_t'(cx), y: display_pkg::coord_t'(cy), left: 1'b0};
            run_pixels(cx - 1, cx + 1, cy - 1, cy + 1);
        end
        cursor = park;
        end_test("cursor");
    endtask

    task automatic click_selection();
        int cx;
        int cy;
        int exp_sq;
        bit on_board;
        for (int p = 0; p < 2; p++)
        begin
            player = p[0];
            repeat (num_clicks)
            begin
                cx = $urandom_range(95, 0);
                cy = $urandom_range(71, 0);
                cursor = '{x: display_pkg::coord_t'(cx), y: display_pkg::coord_t'(cy), left: 1'b1};
                step();
                cursor.left = 1'b0;
                on_board = cx >= 16 && cx <= 79 && cy < 64;
                check_value("selection.valid", {15'b0, selection.valid}, {15'b0, on_board});
                exp_sq = (cy / 8) * 8 + (cx - 16) / 8;
                if (p == 1)
                    exp_sq = 63 - exp_sq;
                if (on_board)
                    check_value("selection.square", {10'b0, selection.square}, 16'(exp_sq));
            end
        end
        player = 1'b0;
        cursor = park;
        end_test("selection");
    endtask

    initial
    begin
        void'($urandom(32'h9aa8_35e9));
        rst_n = 1'b0;
        player = 1'b0;
        // white square pixel, so a missing reset would show as nonzero
        pix_index = display_pkg::pix_idx_t'(`BOARD_X0);
        cursor = park;
        move = '0;
        for (int i = 0; i < 64; i++)
            model[i] = opening_square(i);
        repeat (2) step();
        rst_n = 1'b1;
        reset_state();
        board_view(1'b0, "opening");
        board_view(1'b1, "rotation");
        random_moves();
        cursor_overlay();
        click_selection();
        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
src/chess_pkg.sv
src/display_pkg.sv
src/board_store.sv
src/glyph_rom.sv
src/pixel_shader.sv
src/square_picker.sv
src/chess_display.sv
verif/tb_chess_display.sv
